//--- rtl/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// System clock and default line rate.
`define UART_CLK_HZ 10000000
`define UART_BAUD 625000

// Clock cycles per bit after reset.
`define UART_DEFAULT_DIV (`UART_CLK_HZ / `UART_BAUD)

// The transmit FIFO holds 2**UART_FIFO_LOG2 bytes.
`define UART_FIFO_LOG2 3

// Register byte offsets.
`define UART_ADDR_TXDATA 4'h0
`define UART_ADDR_STATUS 4'h4
`define UART_ADDR_DIV 4'h8

`endif

//--- rtl/axiLitePkg.sv
package axiLitePkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic [3:0] addr;
    } awChan_s;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } wChan_s;

    typedef struct packed {
        logic [3:0] addr;
    } arChan_s;

    typedef struct packed {
        logic [31:0] data;
        resp_e       resp;
    } rChan_s;

endpackage

//--- rtl/uartPkg.sv
package uartPkg;

    // One byte as it travels through the transmit FIFO.
    typedef logic [7:0] txByte_t;

    typedef struct packed {
        logic [23:0] reserved;
        txByte_t     data;
    } txDataReg_s;

    typedef struct packed {
        logic [15:0] reserved;
        logic [15:0] divisor;
    } ctrlReg_s;

    // The same write word seen as TXDATA or as DIV, chosen by the address.
    typedef union packed {
        txDataReg_s tx;
        ctrlReg_s   ctrl;
    } regWord_u;

    typedef struct packed {
        logic [24:0] reserved;
        logic        txBusy;
        logic        empty;
        logic        full;
        logic [3:0]  level;
    } status_s;

endpackage

//--- rtl/uartRegs.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartRegs (
    input  logic                clk,
    input  logic                arstN,
    input  axiLitePkg::awChan_s aw,
    input  logic                awValid,
    output logic                awReady,
    input  axiLitePkg::wChan_s  w,
    input  logic                wValid,
    output logic                wReady,
    output logic                bValid,
    output axiLitePkg::resp_e   bResp,
    input  logic                bReady,
    input  axiLitePkg::arChan_s ar,
    input  logic                arValid,
    output logic                arReady,
    output logic                rValid,
    output axiLitePkg::rChan_s  r,
    input  logic                rReady,
    input  logic                fifoFull,
    input  logic [3:0]          fifoLevel,
    input  logic                txBusy,
    output logic                pushValid,
    output uartPkg::txByte_t    pushData,
    output logic [15:0]         divisor
);

    uartPkg::regWord_u wrWord;
    uartPkg::status_s  statusWord;
    logic              wrFire;
    logic              rdFire;
    logic              wrTx;
    logic              wrDiv;
    logic              wrKnown;

    // AW and W are taken together, and only while no write response waits.
    assign wrFire  = awValid && wValid && !bValid;
    assign awReady = wrFire;
    assign wReady  = wrFire;

    assign wrWord  = w.data;
    assign wrTx    = (aw.addr == `UART_ADDR_TXDATA);
    assign wrDiv   = (aw.addr == `UART_ADDR_DIV);
    assign wrKnown = wrTx || wrDiv || (aw.addr == `UART_ADDR_STATUS);

    // A byte written while the FIFO is full is dropped.
    assign pushValid = wrFire && wrTx && !fifoFull;
    assign pushData  = wrWord.tx.data;

    assign rdFire  = arValid && !rValid;
    assign arReady = rdFire;

    always_comb begin
        statusWord        = '0;
        statusWord.level  = fifoLevel;
        statusWord.full   = fifoFull;
        statusWord.empty  = (fifoLevel == 4'd0);
        statusWord.txBusy = txBusy;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bValid  <= 1'b0;
            rValid  <= 1'b0;
            divisor <= 16'(`UART_DEFAULT_DIV);
        end else begin
            if (wrFire) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (rdFire) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
            if (wrFire && wrDiv && (w.strb[1:0] == 2'b11)) begin
                divisor <= wrWord.ctrl.divisor;  // Both divisor bytes must be strobed.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrFire) begin
            if (!wrKnown || (wrTx && fifoFull)) begin
                bResp <= axiLitePkg::RESP_SLVERR;
            end else begin
                bResp <= axiLitePkg::RESP_OKAY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            r.resp <= axiLitePkg::RESP_OKAY;
            case (ar.addr)
                `UART_ADDR_STATUS: begin
                    r.data <= statusWord;
                end
                `UART_ADDR_DIV: begin
                    r.data <= {16'h0000, divisor};
                end
                `UART_ADDR_TXDATA: begin
                    r.data <= '0;  // Transmit data is write only.
                end
                default: begin
                    r.data <= '0;
                    r.resp <= axiLitePkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

//--- rtl/byteFifo.sv
`timescale 1ns/1ps

module byteFifo #(
    parameter int depthLog2 = 3
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 pushValid,
    input  uartPkg::txByte_t     pushData,
    input  logic                 popReady,
    output logic                 full,
    output logic [depthLog2:0]   level,
    output logic                 popValid,
    output uartPkg::txByte_t     popData
);

    localparam int depth = 1 << depthLog2;

    uartPkg::txByte_t     mem [depth];
    logic [depthLog2-1:0] wrPtr;
    logic [depthLog2-1:0] rdPtr;
    logic                 doPush;
    logic                 doPop;

    assign full     = level[depthLog2];  // The level reaches the top bit only at depth.
    assign popValid = (level != '0);
    assign popData  = mem[rdPtr];

    assign doPush = pushValid && !full;
    assign doPop  = popReady && popValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Pointers wrap at depth.
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

//--- rtl/uartTx.sv
`timescale 1ns/1ps

module uartTx (
    input  logic             clk,
    input  logic             arstN,
    input  logic             popValid,
    input  uartPkg::txByte_t popData,
    input  logic [15:0]      divisor,
    output logic             popReady,
    output logic             txd,
    output logic             busy
);

    typedef enum logic [2:0] {
        Idle,
        Start,
        Data,
        Stop,
        Gap
    } txState_e;

    txState_e         state;
    logic [15:0]      bitDiv;
    logic [15:0]      cycleCnt;
    logic [2:0]       bitIdx;
    uartPkg::txByte_t shiftReg;
    logic             bitEnd;
    logic             doPop;

    // The gap cycle is idle line time, so the next byte may be taken there.
    assign popReady = (state == Idle) || (state == Gap);
    assign doPop    = popReady && popValid;
    assign bitEnd   = (cycleCnt == bitDiv - 16'd1);
    assign busy     = (state != Idle);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= Idle;
            txd      <= 1'b1;
            cycleCnt <= '0;
            bitIdx   <= '0;
        end else begin
            case (state)
                Idle, Gap: begin
                    if (doPop) begin
                        state    <= Start;
                        txd      <= 1'b0;
                        cycleCnt <= '0;
                    end else begin
                        state <= Idle;
                    end
                end
                Start: begin
                    if (bitEnd) begin
                        state    <= Data;
                        txd      <= shiftReg[0];
                        cycleCnt <= '0;
                        bitIdx   <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 16'd1;
                    end
                end
                Data: begin
                    if (bitEnd) begin
                        cycleCnt <= '0;
                        if (bitIdx == 3'd7) begin
                            state <= Stop;
                            txd   <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                            txd    <= shiftReg[0];
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 16'd1;
                    end
                end
                Stop: begin
                    if (bitEnd) begin
                        state    <= Gap;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 16'd1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Byte and bit period are frozen for the whole frame.
    always_ff @(posedge clk) begin
        if (doPop) begin
            shiftReg <= popData;
            bitDiv   <= divisor;
        end else if (bitEnd && ((state == Start) || (state == Data))) begin
            shiftReg <= {1'b0, shiftReg[7:1]};  // LSB goes out first.
        end
    end

endmodule

//--- rtl/uartTop.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartTop (
    input  logic                clk,
    input  logic                arstN,
    input  axiLitePkg::awChan_s aw,
    input  logic                awValid,
    output logic                awReady,
    input  axiLitePkg::wChan_s  w,
    input  logic                wValid,
    output logic                wReady,
    output logic                bValid,
    output axiLitePkg::resp_e   bResp,
    input  logic                bReady,
    input  axiLitePkg::arChan_s ar,
    input  logic                arValid,
    output logic                arReady,
    output logic                rValid,
    output axiLitePkg::rChan_s  r,
    input  logic                rReady,
    output logic                txd
);

    logic                     pushValid;
    uartPkg::txByte_t         pushData;
    logic                     fifoFull;
    logic [`UART_FIFO_LOG2:0] fifoLevel;
    logic                     popValid;
    uartPkg::txByte_t         popData;
    logic                     popReady;
    logic [15:0]              divisor;
    logic                     txBusy;

    uartRegs u_regs (
        .clk       (clk),
        .arstN     (arstN),
        .aw        (aw),
        .awValid   (awValid),
        .awReady   (awReady),
        .w         (w),
        .wValid    (wValid),
        .wReady    (wReady),
        .bValid    (bValid),
        .bResp     (bResp),
        .bReady    (bReady),
        .ar        (ar),
        .arValid   (arValid),
        .arReady   (arReady),
        .rValid    (rValid),
        .r         (r),
        .rReady    (rReady),
        .fifoFull  (fifoFull),
        .fifoLevel (fifoLevel),
        .txBusy    (txBusy),
        .pushValid (pushValid),
        .pushData  (pushData),
        .divisor   (divisor)
    );

    byteFifo #(
        .depthLog2 (`UART_FIFO_LOG2)
    ) u_fifo (
        .clk       (clk),
        .arstN     (arstN),
        .pushValid (pushValid),
        .pushData  (pushData),
        .popReady  (popReady),
        .full      (fifoFull),
        .level     (fifoLevel),
        .popValid  (popValid),
        .popData   (popData)
    );

    uartTx u_tx (
        .clk      (clk),
        .arstN    (arstN),
        .popValid (popValid),
        .popData  (popData),
        .divisor  (divisor),
        .popReady (popReady),
        .txd      (txd),
        .busy     (txBusy)
    );

endmodule

//--- tests/uartTb_asserts.sv
`timescale 1ns/1ps

module uartPortChecks (
    input logic        clk,
    input logic        arstN,
    input logic        txd,
    input logic        awValid,
    input logic        awReady,
    input logic        arValid,
    input logic        arReady,
    input logic        bValid,
    input logic        bReady,
    input logic        rValid,
    input logic        rReady,
    input logic [15:0] divisor
);

    int          failCount = 0;
    logic        busUsed;
    logic        inFrame;
    logic [31:0] frameCnt;  // Cycles since the falling edge that opened the frame.
    logic [15:0] frameDiv;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busUsed  <= 1'b0;
            inFrame  <= 1'b0;
            frameCnt <= '0;
            frameDiv <= '0;
        end else begin
            busUsed <= busUsed || (awValid && awReady) || (arValid && arReady);
            if (!inFrame && !txd) begin
                inFrame  <= 1'b1;
                frameCnt <= 32'd1;
                frameDiv <= divisor;  // Same value the transmitter took at the pop.
            end else if (inFrame) begin
                inFrame  <= (frameCnt != 32'(frameDiv) * 32'd10 - 32'd1);
                frameCnt <= frameCnt + 32'd1;
            end
        end
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (!arstN)
        !busUsed |-> txd && !bValid && !rValid)
        else begin
            failCount++;
            $error("The line or a bus response was active before the first bus access");
        end

    startBitLength: assert property (@(posedge clk) disable iff (!arstN)
        inFrame && (frameCnt < 32'(frameDiv)) |-> !txd)
        else begin
            failCount++;
            $error("The start bit ended before a full bit period");
        end

    stopBitHigh: assert property (@(posedge clk) disable iff (!arstN)
        inFrame && (frameCnt >= 32'(frameDiv) * 32'd9) |-> txd)
        else begin
            failCount++;
            $error("The stop bit was not high");
        end

    bValidHold: assert property (@(posedge clk) disable iff (!arstN)
        bValid && !bReady |=> bValid)
        else begin
            failCount++;
            $error("The write response was dropped before it was accepted");
        end

    rValidHold: assert property (@(posedge clk) disable iff (!arstN)
        rValid && !rReady |=> rValid)
        else begin
            failCount++;
            $error("The read data was dropped before it was accepted");
        end

endmodule

bind uartTop uartPortChecks u_asserts (.*);

//--- tests/uartTb.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartTb;

    localparam int handshakeLimit = 64;
    localparam int drainLimit     = 4000;

    logic                clk;
    logic                arstN;
    axiLitePkg::awChan_s aw;
    logic                awValid;
    logic                awReady;
    axiLitePkg::wChan_s  w;
    logic                wValid;
    logic                wReady;
    logic                bValid;
    axiLitePkg::resp_e   bResp;
    logic                bReady;
    axiLitePkg::arChan_s ar;
    logic                arValid;
    logic                arReady;
    logic                rValid;
    axiLitePkg::rChan_s  r;
    logic                rReady;
    logic                txd;

    int          errors;
    int          bitCycles;  // Bit period the decoder samples with.
    logic [31:0] lfsr;
    logic [7:0]  expQ [$];
    string       testName;
    logic        decoding;   // High while the decoder is inside a frame.

    uartTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] randomByte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrNext(lfsr);
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] want,
                              input logic [31:0] got);
        assert (got == want) else begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", testName, what, want, got);
        end
    endtask

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            output axiLitePkg::resp_e resp);
        int n;
        aw.addr <= addr;
        w.data  <= data;
        w.strb  <= 4'hf;
        awValid <= 1'b1;
        wValid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(awReady && wReady) && n < handshakeLimit);
        if (!(awReady && wReady)) begin
            errors++;
            $display("Write address and data to offset %h were never accepted in test %s",
                     addr, testName);
        end
        awValid <= 1'b0;
        wValid  <= 1'b0;
        n = 0;
        while (!bValid && n < handshakeLimit) begin
            @(posedge clk);
            n++;
        end
        if (!bValid) begin
            errors++;
            $display("Write to offset %h got no response in test %s", addr, testName);
        end
        resp = bResp;
        bReady <= 1'b1;  // One cycle late, so bValid has to hold.
        @(posedge clk);
        bReady <= 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
                           output axiLitePkg::resp_e resp);
        int n;
        ar.addr <= addr;
        arValid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arReady && n < handshakeLimit);
        if (!arReady) begin
            errors++;
            $display("Read address %h was never accepted in test %s", addr, testName);
        end
        arValid <= 1'b0;
        n = 0;
        while (!rValid && n < handshakeLimit) begin
            @(posedge clk);
            n++;
        end
        if (!rValid) begin
            errors++;
            $display("Read at offset %h got no response in test %s", addr, testName);
        end
        data = r.data;
        resp = r.resp;
        rReady <= 1'b1;
        @(posedge clk);
        rReady <= 1'b0;
    endtask

    task automatic sendByte(input logic [7:0] b, output axiLitePkg::resp_e resp);
        axiWrite(`UART_ADDR_TXDATA, {24'h0, b}, resp);
        if (resp == axiLitePkg::RESP_OKAY) begin
            expQ.push_back(b);
        end
    endtask

    task automatic decodeFrame();
        logic [7:0] got;
        repeat (bitCycles / 2) @(posedge clk);  // Middle of the start bit.
        for (int i = 0; i < 8; i++) begin
            repeat (bitCycles) @(posedge clk);
            got[i] = txd;
        end
        if (expQ.size() == 0) begin
            errors++;
            $display("Byte %h arrived on txd without an accepted write", got);
        end else begin
            checkValue("received byte", expQ.pop_front(), got);
        end
        repeat (bitCycles) @(posedge clk);
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < drainLimit) begin
            @(posedge clk);
            n++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d accepted bytes never appeared on txd in test %s", expQ.size(), testName);
        end
        repeat (2 * bitCycles) @(posedge clk);  // Rest of the stop bit and the gap cycle.
        if (decoding || !txd) begin
            errors++;
            $display("A frame started on txd with no accepted byte left in test %s", testName);
        end
    endtask

    initial begin
        logic lineHigh;
        lineHigh = 1'b0;
        decoding = 1'b0;
        forever begin
            @(posedge clk);
            if (arstN && lineHigh && !txd) begin
                decoding = 1'b1;
                decodeFrame();
                decoding = 1'b0;
            end
            lineHigh = txd;
        end
    end

    initial begin
        axiLitePkg::resp_e resp;
        logic [31:0]       rdata;
        uartPkg::status_s  status;
        int                refused;
        arstN     = 1'b0;
        aw        = '0;
        awValid   = 1'b0;
        w         = '0;
        wValid    = 1'b0;
        bReady    = 1'b0;
        ar        = '0;
        arValid   = 1'b0;
        rReady    = 1'b0;
        errors    = 0;
        bitCycles = `UART_DEFAULT_DIV;
        lfsr      = 32'h3b2e_ca9f;
        testName  = "reset";
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        testName = "defaultDiv";
        for (int i = 0; i < 6; i++) begin
            sendByte(randomByte(), resp);
            checkValue("write response", axiLitePkg::RESP_OKAY, resp);
        end
        waitDrained();
        axiRead(`UART_ADDR_STATUS, rdata, resp);
        checkValue("read response", axiLitePkg::RESP_OKAY, resp);
        status = rdata;
        checkValue("status level", 0, status.level);
        checkValue("status empty", 1, status.empty);
        checkValue("status full", 0, status.full);
        checkValue("status txBusy", 0, status.txBusy);

        testName = "divisorChange";
        axiWrite(`UART_ADDR_DIV, 32'd8, resp);
        checkValue("write response", axiLitePkg::RESP_OKAY, resp);
        axiRead(`UART_ADDR_DIV, rdata, resp);
        checkValue("read response", axiLitePkg::RESP_OKAY, resp);
        checkValue("divisor read-back", 32'd8, rdata);
        bitCycles = 8;
        for (int i = 0; i < 4; i++) begin
            sendByte(randomByte(), resp);
            checkValue("write response", axiLitePkg::RESP_OKAY, resp);
        end
        waitDrained();

        testName = "fullFifo";
        axiWrite(`UART_ADDR_DIV, `UART_DEFAULT_DIV, resp);
        checkValue("write response", axiLitePkg::RESP_OKAY, resp);
        bitCycles = `UART_DEFAULT_DIV;
        refused = 0;
        for (int i = 0; i < 10; i++) begin
            sendByte(randomByte(), resp);
            if (resp == axiLitePkg::RESP_SLVERR) begin
                refused++;
            end
        end
        assert (refused > 0) else begin
            errors++;
            $display("No write was refused while the FIFO was full");
        end
        waitDrained();

        testName = "unknownAddr";
        axiWrite(4'hc, 32'h0, resp);
        checkValue("write response", axiLitePkg::RESP_SLVERR, resp);
        axiRead(4'hc, rdata, resp);
        checkValue("read response", axiLitePkg::RESP_SLVERR, resp);

        repeat (4) @(posedge clk);
        $display("Testbench errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_asserts.failCount);
        if (errors == 0 && u_dut.u_asserts.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/axiLitePkg.sv
rtl/uartPkg.sv
rtl/uartRegs.sv
rtl/byteFifo.sv
rtl/uartTx.sv
rtl/uartTop.sv
tests/uartTb_asserts.sv
tests/uartTb.sv

//--- Bender.yml
package:
  name: uart_tx_axil

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axiLitePkg.sv
      - rtl/uartPkg.sv
      - rtl/uartRegs.sv
      - rtl/byteFifo.sv
      - rtl/uartTx.sv
      - rtl/uartTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/uartTb_asserts.sv
      - tests/uartTb.sv
